// ==== include/noc_widths.svh ====
`ifndef NOC_WIDTHS_SVH
`define NOC_WIDTHS_SVH

// one flit on the NoC link.
`define NOC_FLIT_W 64

// number of body flits that follow the header.
`define MSG_LEN_W 8

`define COORD_W 4
`define PACKET_ID_W 16
`define MSG_TYPE_W 4

`endif

// ==== src/noc_msg_pkg.sv ====
`include "noc_widths.svh"

package noc_msg_pkg;

    localparam int NOC_FLIT_W  = `NOC_FLIT_W;
    localparam int MSG_LEN_W   = `MSG_LEN_W;
    localparam int COORD_W     = `COORD_W;
    localparam int PACKET_ID_W = `PACKET_ID_W;
    localparam int MSG_TYPE_W  = `MSG_TYPE_W;

    // the header fields sit at the top of the flit, the rest is unused.
    localparam int HDR_PAD_W = NOC_FLIT_W - 2 * COORD_W - MSG_TYPE_W
                               - MSG_LEN_W - PACKET_ID_W;

    typedef struct packed {
        logic [COORD_W-1:0]     dst_x;
        logic [COORD_W-1:0]     dst_y;
        logic [MSG_TYPE_W-1:0]  msg_type;
        logic [MSG_LEN_W-1:0]   msg_len;
        logic [PACKET_ID_W-1:0] packet_id;
        logic [HDR_PAD_W-1:0]   padding;
    } noc_hdr_flit_t;

    // a flit is a header or a body word, depending on where it falls in the message.
    typedef union packed {
        noc_hdr_flit_t         hdr;
        logic [NOC_FLIT_W-1:0] raw;
    } noc_flit_u;

endpackage

// ==== src/tracker_pkg.sv ====
package tracker_pkg;

    localparam int TIMESTAMP_W = 32;

    localparam int LOG_DEPTH_DEF = 16;

    // one recorded message in the log.
    typedef struct packed {
        logic [noc_msg_pkg::PACKET_ID_W-1:0] packet_id;
        logic [TIMESTAMP_W-1:0]              timestamp;
        logic [noc_msg_pkg::MSG_LEN_W-1:0]   msg_len;
        logic [noc_msg_pkg::COORD_W-1:0]     dst_x;
        logic [noc_msg_pkg::COORD_W-1:0]     dst_y;
    } tracker_entry_t;

endpackage

// ==== src/tracker_ifs.sv ====
interface tracker_ctrl_if;
    logic store_hdr;
    logic incr_flits;
    logic last_flit;
    logic hdr_zero_len;

    modport ctrl (output store_hdr, output incr_flits, input last_flit, input hdr_zero_len);
    modport datap (input store_hdr, input incr_flits, output last_flit, output hdr_zero_len);
endinterface

interface tracker_rec_if;
    import noc_msg_pkg::*;
    import tracker_pkg::*;

    tracker_entry_t entry;
    noc_hdr_flit_t  flit_hdr;
    logic           wr;
    logic           match;
    // high while the control waits for a header.
    logic           idle;

    modport src_datap (output entry, output flit_hdr);
    modport src_ctrl (output wr, output idle, input match);
    modport filt (input flit_hdr, input idle, output match);
    modport log (input entry, input wr);
endinterface

// ==== src/tracker_record_ctrl.sv ====
module tracker_record_ctrl (
    input  logic              clk,
    input  logic              rst,
    tracker_ctrl_if.ctrl      ctrl_if,
    tracker_rec_if.src_ctrl   rec_if,
    input  logic              flit_in_val
);

    typedef enum logic {
        ST_HDR,
        ST_BODY
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   match_q;
    logic   hdr_acc;
    logic   body_acc;

    assign hdr_acc  = flit_in_val && (state_q == ST_HDR);
    assign body_acc = flit_in_val && (state_q == ST_BODY);

    assign ctrl_if.store_hdr  = hdr_acc;
    assign ctrl_if.incr_flits = body_acc;
    assign rec_if.idle        = (state_q == ST_HDR);

    // a zero-length message is written in its own header cycle, so the live
    // match is used there; longer messages use the match latched at the header.
    assign rec_if.wr = hdr_acc ? (rec_if.match && ctrl_if.hdr_zero_len)
                               : (body_acc && match_q && ctrl_if.last_flit);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_HDR: begin
                if (hdr_acc && !ctrl_if.hdr_zero_len) begin
                    state_d = ST_BODY;
                end
            end
            ST_BODY: begin
                if (body_acc && ctrl_if.last_flit) begin
                    state_d = ST_HDR;
                end
            end
            default: state_d = ST_HDR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_HDR;
            match_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (hdr_acc) begin
                match_q <= rec_if.match;
            end
        end
    end

endmodule

// ==== src/tracker_record_datap.sv ====
module tracker_record_datap (
    input  logic                    clk,
    input  logic                    rst,
    input  noc_msg_pkg::noc_flit_u  flit_in,
    input  logic                    flit_in_val,
    output noc_msg_pkg::noc_flit_u  flit_out,
    output logic                    flit_out_val,
    tracker_ctrl_if.datap           ctrl_if,
    tracker_rec_if.src_datap        rec_if
);
    import noc_msg_pkg::*;
    import tracker_pkg::*;

    noc_hdr_flit_t          hdr;
    logic [MSG_LEN_W-1:0]   total_flits_q;
    logic [MSG_LEN_W-1:0]   total_flits_d;
    logic [MSG_LEN_W-1:0]   curr_flits_q;
    logic [MSG_LEN_W-1:0]   curr_flits_d;
    logic [PACKET_ID_W-1:0] packet_id_q;
    logic [COORD_W-1:0]     dst_x_q;
    logic [COORD_W-1:0]     dst_y_q;
    logic [TIMESTAMP_W-1:0] ts_q;
    logic [TIMESTAMP_W-1:0] hdr_ts_q;

    assign flit_out     = flit_in;
    assign flit_out_val = flit_in_val;

    assign hdr             = flit_in.hdr;
    assign rec_if.flit_hdr = hdr;

    assign total_flits_d = ctrl_if.store_hdr ? hdr.msg_len : total_flits_q;
    assign curr_flits_d  = ctrl_if.store_hdr  ? '0 :
                           ctrl_if.incr_flits ? curr_flits_q + 1'b1 : curr_flits_q;

    // comparing the next values lets a header with zero length end on itself.
    assign ctrl_if.last_flit    = (curr_flits_d == total_flits_d);
    assign ctrl_if.hdr_zero_len = (total_flits_d == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            ts_q          <= '0;
            total_flits_q <= '0;
            curr_flits_q  <= '0;
        end else begin
            ts_q          <= ts_q + 1'b1;
            total_flits_q <= total_flits_d;
            curr_flits_q  <= curr_flits_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_if.store_hdr) begin
            packet_id_q <= hdr.packet_id;
            dst_x_q     <= hdr.dst_x;
            dst_y_q     <= hdr.dst_y;
            hdr_ts_q    <= ts_q;
        end
    end

    always_comb begin
        rec_if.entry.msg_len = total_flits_d;
        if (ctrl_if.store_hdr) begin
            rec_if.entry.packet_id = hdr.packet_id;
            rec_if.entry.timestamp = ts_q;
            rec_if.entry.dst_x     = hdr.dst_x;
            rec_if.entry.dst_y     = hdr.dst_y;
        end else begin
            rec_if.entry.packet_id = packet_id_q;
            rec_if.entry.timestamp = hdr_ts_q;
            rec_if.entry.dst_x     = dst_x_q;
            rec_if.entry.dst_y     = dst_y_q;
        end
    end

endmodule

// ==== src/tracker_dst_filter.sv ====
module tracker_dst_filter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                filter_en,
    input  logic [noc_msg_pkg::COORD_W-1:0]     filter_dst_x,
    input  logic [noc_msg_pkg::COORD_W-1:0]     filter_dst_y,
    input  logic [noc_msg_pkg::MSG_TYPE_W-1:0]  filter_type,
    tracker_rec_if.filt                         rec_if
);
    import noc_msg_pkg::*;

    logic                  cfg_en_q;
    logic [COORD_W-1:0]    cfg_x_q;
    logic [COORD_W-1:0]    cfg_y_q;
    logic [MSG_TYPE_W-1:0] cfg_type_q;
    logic                  hit;

    // the configuration only moves between messages.
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_en_q   <= 1'b0;
            cfg_x_q    <= '0;
            cfg_y_q    <= '0;
            cfg_type_q <= '0;
        end else if (rec_if.idle) begin
            cfg_en_q   <= filter_en;
            cfg_x_q    <= filter_dst_x;
            cfg_y_q    <= filter_dst_y;
            cfg_type_q <= filter_type;
        end
    end

    assign hit = (rec_if.flit_hdr.dst_x == cfg_x_q)
              && (rec_if.flit_hdr.dst_y == cfg_y_q)
              && (rec_if.flit_hdr.msg_type == cfg_type_q);

    // with the filter off every message is recorded.
    assign rec_if.match = !cfg_en_q || hit;

endmodule

// ==== src/tracker_log_mem.sv ====
module tracker_log_mem #(
    parameter int LOG_DEPTH = tracker_pkg::LOG_DEPTH_DEF
) (
    input  logic                                clk,
    input  logic                                rst,
    tracker_rec_if.log                          rec_if,
    input  logic [$clog2(LOG_DEPTH)-1:0]        rd_addr,
    output tracker_pkg::tracker_entry_t         rd_data,
    output logic [$clog2(LOG_DEPTH+1)-1:0]      log_count
);
    import tracker_pkg::*;

    localparam int ADDR_W = $clog2(LOG_DEPTH);
    localparam int CNT_W  = $clog2(LOG_DEPTH + 1);

    tracker_entry_t    mem [LOG_DEPTH];
    logic [ADDR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              full;

    assign full      = (count_q == CNT_W'(LOG_DEPTH));
    assign log_count = count_q;

    // the depth is a power of two, so the pointer wraps by itself.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
        end else if (rec_if.wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    // once full, the oldest entry is overwritten and the count holds.
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (rec_if.wr && !full) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rec_if.wr) begin
            mem[wr_ptr_q] <= rec_if.entry;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== src/flit_tracker_top.sv ====
module flit_tracker_top #(
    parameter int LOG_DEPTH = tracker_pkg::LOG_DEPTH_DEF
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [noc_msg_pkg::NOC_FLIT_W-1:0]  flit_in,
    input  logic                                flit_in_val,
    output logic [noc_msg_pkg::NOC_FLIT_W-1:0]  flit_out,
    output logic                                flit_out_val,

    input  logic                                filter_en,
    input  logic [noc_msg_pkg::COORD_W-1:0]     filter_dst_x,
    input  logic [noc_msg_pkg::COORD_W-1:0]     filter_dst_y,
    input  logic [noc_msg_pkg::MSG_TYPE_W-1:0]  filter_type,

    input  logic [$clog2(LOG_DEPTH)-1:0]        rd_addr,
    output tracker_pkg::tracker_entry_t         rd_data,
    output logic [$clog2(LOG_DEPTH+1)-1:0]      log_count
);

    tracker_ctrl_if ctrl_if ();
    tracker_rec_if  rec_if ();

    tracker_record_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ctrl_if     (ctrl_if.ctrl),
        .rec_if      (rec_if.src_ctrl),
        .flit_in_val (flit_in_val)
    );

    tracker_record_datap u_datap (
        .clk          (clk),
        .rst          (rst),
        .flit_in      (flit_in),
        .flit_in_val  (flit_in_val),
        .flit_out     (flit_out),
        .flit_out_val (flit_out_val),
        .ctrl_if      (ctrl_if.datap),
        .rec_if       (rec_if.src_datap)
    );

    tracker_dst_filter u_filter (
        .clk          (clk),
        .rst          (rst),
        .filter_en    (filter_en),
        .filter_dst_x (filter_dst_x),
        .filter_dst_y (filter_dst_y),
        .filter_type  (filter_type),
        .rec_if       (rec_if.filt)
    );

    tracker_log_mem #(
        .LOG_DEPTH (LOG_DEPTH)
    ) u_log (
        .clk       (clk),
        .rst       (rst),
        .rec_if    (rec_if.log),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .log_count (log_count)
    );

endmodule

// ==== bench/flit_tracker_properties.sv ====
module flit_tracker_properties #(
    parameter int LOG_DEPTH = tracker_pkg::LOG_DEPTH_DEF
) (
    input logic                                clk,
    input logic                                rst,
    input logic [noc_msg_pkg::NOC_FLIT_W-1:0]  flit_in,
    input logic                                flit_in_val,
    input logic [noc_msg_pkg::NOC_FLIT_W-1:0]  flit_out,
    input logic                                flit_out_val,
    input logic [$clog2(LOG_DEPTH+1)-1:0]      log_count,
    input logic                                wr,
    input tracker_pkg::tracker_entry_t         entry
);
    import tracker_pkg::*;

    localparam int CNT_W = $clog2(LOG_DEPTH + 1);

    logic                   seen_q;
    logic [TIMESTAMP_W-1:0] last_ts_q;

    // timestamp of the most recent log write.
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_q    <= 1'b0;
            last_ts_q <= '0;
        end else if (wr) begin
            seen_q    <= 1'b1;
            last_ts_q <= entry.timestamp;
        end
    end

    a_pass_through: assert property (@(posedge clk)
        (flit_out == flit_in) && (flit_out_val == flit_in_val))
        else $error("flit output differs from the flit input");

    a_wr_with_flit: assert property (@(posedge clk) disable iff (rst) wr |-> flit_in_val)
        else $error("log write in a cycle without a valid flit");

    a_count_limit: assert property (@(posedge clk) disable iff (rst)
        log_count <= CNT_W'(LOG_DEPTH))
        else $error("log count above the log depth");

    a_count_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (log_count == $past(log_count))
                     || (log_count == $past(log_count) + CNT_W'(1)))
        else $error("log count moved by more than one entry");

    a_idle_after_reset: assert property (@(posedge clk)
        $past(rst) |-> (log_count == '0) && !wr)
        else $error("log not empty and idle after reset");

    a_ts_rising: assert property (@(posedge clk) disable iff (rst)
        (wr && seen_q) |-> (entry.timestamp > last_ts_q))
        else $error("log entry timestamp not above the previous one");

endmodule

bind flit_tracker_top flit_tracker_properties #(
    .LOG_DEPTH (LOG_DEPTH)
) i_props (
    .clk          (clk),
    .rst          (rst),
    .flit_in      (flit_in),
    .flit_in_val  (flit_in_val),
    .flit_out     (flit_out),
    .flit_out_val (flit_out_val),
    .log_count    (log_count),
    .wr           (rec_if.wr),
    .entry        (rec_if.entry)
);

// ==== bench/flit_tracker_tb.sv ====
module flit_tracker_tb;
    import noc_msg_pkg::*;
    import tracker_pkg::*;

    localparam int LOG_DEPTH  = 8;
    localparam int ADDR_W     = $clog2(LOG_DEPTH);
    localparam int CNT_W      = $clog2(LOG_DEPTH + 1);
    localparam int MAX_GAP    = 3;
    localparam int PASS_FLITS = 48;
    localparam int FILT_MSGS  = 6;
    localparam int WRAP_MSGS  = 11;
    // worst case flits over all tests, each taking at most MAX_GAP + 1 cycles.
    localparam int MAX_FLITS  = PASS_FLITS + 21 + FILT_MSGS * 5 + 10 + WRAP_MSGS * 4;
    localparam int WATCHDOG_CYCLES = MAX_FLITS * (MAX_GAP + 1) + 500;

    logic                   clk;
    logic                   rst;
    logic [NOC_FLIT_W-1:0]  flit_in;
    logic                   flit_in_val;
    logic [NOC_FLIT_W-1:0]  flit_out;
    logic                   flit_out_val;
    logic                   filter_en;
    logic [COORD_W-1:0]     filter_dst_x;
    logic [COORD_W-1:0]     filter_dst_y;
    logic [MSG_TYPE_W-1:0]  filter_type;
    logic [ADDR_W-1:0]      rd_addr;
    tracker_entry_t         rd_data;
    logic [CNT_W-1:0]       log_count;

    // cycles since reset, which is what the header timestamp should show.
    logic [TIMESTAMP_W-1:0] cyc;
    tracker_entry_t         exp_q[$];
    int                     rec_total;
    logic                   cfg_en;
    logic [COORD_W-1:0]     cfg_x;
    logic [COORD_W-1:0]     cfg_y;
    logic [MSG_TYPE_W-1:0]  cfg_type;
    logic                   flip_en;
    logic [COORD_W-1:0]     flip_x;
    string                  cur_test;
    int                     test_checks;
    int                     test_errors;
    int                     tests_run;
    int                     tests_failed;
    int                     total_checks;
    int                     total_errors;

    flit_tracker_top #(
        .LOG_DEPTH (LOG_DEPTH)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + TIMESTAMP_W'(1);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare_value(input string what, input logic [127:0] exp,
                                 input logic [127:0] act);
        test_checks++;
        assert (act === exp) else begin
            test_errors++;
            $display("[ERROR] %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic finish_test();
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic drive_flit(input logic [NOC_FLIT_W-1:0] data, input logic val);
        @(posedge clk);
        flit_in     <= data;
        flit_in_val <= val;
    endtask

    task automatic drive_gap();
        repeat ($urandom_range(0, MAX_GAP)) drive_flit({$urandom, $urandom}, 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst         <= 1'b1;
        flit_in_val <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        exp_q.delete();
        rec_total = 0;
    endtask

    // the filter registers a new setting only in a cycle without a message.
    task automatic set_filter(input logic en, input logic [COORD_W-1:0] x,
                              input logic [COORD_W-1:0] y, input logic [MSG_TYPE_W-1:0] t);
        drive_flit({$urandom, $urandom}, 1'b0);
        filter_en    <= en;
        filter_dst_x <= x;
        filter_dst_y <= y;
        filter_type  <= t;
        cfg_en   = en;
        cfg_x    = x;
        cfg_y    = y;
        cfg_type = t;
    endtask

    task automatic send_message(input logic [COORD_W-1:0] dx, input logic [COORD_W-1:0] dy,
                                input logic [MSG_TYPE_W-1:0] mt, input logic [MSG_LEN_W-1:0] len,
                                input logic [PACKET_ID_W-1:0] id, input logic cfg_flip);
        noc_flit_u      hdr_flit;
        tracker_entry_t ent;
        logic           hit;
        hdr_flit.raw          = {$urandom, $urandom};
        hdr_flit.hdr.dst_x    = dx;
        hdr_flit.hdr.dst_y    = dy;
        hdr_flit.hdr.msg_type = mt;
        hdr_flit.hdr.msg_len  = len;
        hdr_flit.hdr.packet_id = id;
        hit = !cfg_en || ((dx == cfg_x) && (dy == cfg_y) && (mt == cfg_type));
        drive_gap();
        drive_flit(hdr_flit.raw, 1'b1);
        ent = '{packet_id: id, timestamp: cyc + TIMESTAMP_W'(1), msg_len: len,
                dst_x: dx, dst_y: dy};
        for (int i = 0; i < int'(len); i++) begin
            drive_gap();
            drive_flit({$urandom, $urandom}, 1'b1);
            if (cfg_flip && (i == 0)) begin
                filter_en    <= flip_en;
                filter_dst_x <= flip_x;
                cfg_en = flip_en;
                cfg_x  = flip_x;
            end
        end
        if (hit) begin
            exp_q.push_back(ent);
            rec_total++;
            if (exp_q.size() > LOG_DEPTH) begin
                void'(exp_q.pop_front());
            end
        end
        if (cfg_flip) begin
            drive_flit({$urandom, $urandom}, 1'b0);
        end
    endtask

    // message k sits in slot k mod LOG_DEPTH, later messages overwrite earlier ones.
    task automatic check_log();
        tracker_entry_t exp_log [LOG_DEPTH];
        bit             filled [LOG_DEPTH];
        int             base;
        base = rec_total - exp_q.size();
        foreach (filled[s]) filled[s] = 1'b0;
        foreach (exp_q[i]) begin
            exp_log[(base + i) % LOG_DEPTH] = exp_q[i];
            filled[(base + i) % LOG_DEPTH]  = 1'b1;
        end
        for (int s = 0; s < LOG_DEPTH; s++) begin
            if (filled[s]) begin
                @(posedge clk);
                rd_addr     <= ADDR_W'(s);
                flit_in_val <= 1'b0;
                @(posedge clk);
                @(negedge clk);
                compare_value($sformatf("slot %0d", s), 128'(exp_log[s]), 128'(rd_data));
            end
        end
        @(negedge clk);
        compare_value("log_count", 128'((rec_total < LOG_DEPTH) ? rec_total : LOG_DEPTH),
                      128'(log_count));
    endtask

    initial begin
        logic [NOC_FLIT_W-1:0] data;
        logic                  val;
        logic [COORD_W-1:0]    dx;
        logic [COORD_W-1:0]    dy;
        logic [MSG_TYPE_W-1:0] mt;
        void'($urandom(79));
        rst          = 1'b1;
        flit_in      = '0;
        flit_in_val  = 1'b0;
        filter_en    = 1'b0;
        filter_dst_x = '0;
        filter_dst_y = '0;
        filter_type  = '0;
        rd_addr      = '0;
        cfg_en       = 1'b0;
        rec_total    = 0;
        test_checks  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_checks = 0;
        total_errors = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        cur_test = "pass_through";
        for (int i = 0; i < PASS_FLITS; i++) begin
            data = {$urandom, $urandom};
            val  = 1'($urandom_range(0, 1));
            drive_flit(data, val);
            @(negedge clk);
            compare_value("flit_out", 128'(data), 128'(flit_out));
            compare_value("flit_out_val", 128'(val), 128'(flit_out_val));
        end
        apply_reset();
        check_log();
        finish_test();

        cur_test = "filter_off";
        for (int len = 0; len <= 5; len++) begin
            send_message(4'($urandom), 4'($urandom), 4'($urandom), 8'(len), 16'($urandom), 1'b0);
        end
        check_log();
        finish_test();

        cur_test = "filter_on";
        apply_reset();
        set_filter(1'b1, 4'($urandom), 4'($urandom), 4'($urandom));
        for (int i = 0; i < FILT_MSGS; i++) begin
            dx = cfg_x;
            dy = cfg_y;
            mt = cfg_type;
            case (i)
                1: dx = dx ^ 4'($urandom_range(1, 15));
                3: dy = dy ^ 4'($urandom_range(1, 15));
                5: mt = mt ^ 4'($urandom_range(1, 15));
                default: ;
            endcase
            send_message(dx, dy, mt, 8'($urandom_range(0, 4)), 16'($urandom), 1'b0);
        end
        check_log();
        finish_test();

        // a matching message stays logged and a missed one stays out.
        cur_test = "filter_change";
        set_filter(1'b1, cfg_x, cfg_y, cfg_type);
        flip_en = 1'b1;
        flip_x  = cfg_x + 4'd1;
        send_message(cfg_x, cfg_y, cfg_type, 8'd4, 16'($urandom), 1'b1);
        flip_en = 1'b0;
        flip_x  = cfg_x;
        send_message(cfg_x + 4'd1, cfg_y, cfg_type, 8'd4, 16'($urandom), 1'b1);
        check_log();
        finish_test();

        cur_test = "wrap";
        set_filter(1'b0, '0, '0, '0);
        for (int i = 0; i < WRAP_MSGS; i++) begin
            send_message(4'($urandom), 4'($urandom), 4'($urandom), 8'($urandom_range(0, 3)),
                         16'($urandom), 1'b0);
        end
        check_log();
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flit_tracker.f ====
+incdir+include
src/noc_msg_pkg.sv
src/tracker_pkg.sv
src/tracker_ifs.sv
src/tracker_record_ctrl.sv
src/tracker_record_datap.sv
src/tracker_dst_filter.sv
src/tracker_log_mem.sv
src/flit_tracker_top.sv
bench/flit_tracker_properties.sv
bench/flit_tracker_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the flit tracker testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
SIM_BIN=obj_dir/flit_tracker_sim

if ! verilator --binary --timing --assert -Wno-fatal \
        -f flit_tracker.f --top-module flit_tracker_tb \
        --Mdir obj_dir -o flit_tracker_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! "./${SIM_BIN}" > "${LOG_FILE}" 2>&1; then
    cat "${LOG_FILE}"
    echo "simulation ended with a non-zero status"
    exit 1
fi
cat "${LOG_FILE}"

if grep -qx "TEST OK" "${LOG_FILE}"; then
    exit 0
fi
echo "pass message not found in ${LOG_FILE}"
exit 1
